// File: src.f
source/dcm_pkg.sv
source/dcm_op_if.sv
source/mult_if.sv
source/fx_mult.sv
source/dcm_datapath.sv
source/dcm_sequencer.sv
source/dcm_top.sv
test/dcm_checker.sv
test/dcm_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= dcm_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= src.f
VFLAGS    ?= --binary --assert --top-module $(TOP)
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: test/dcm_tb.sv
module dcm_tb import dcm_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int DATA_W = 32;
	localparam int FRAC_W = 30;
	localparam int N_RAND = 20;
	localparam int N_RUNS = N_RAND + 2;   // identity, random set, start while busy
	localparam int MAX_CYCLES = N_RUNS * (PROG_LEN + 1) * (DATA_W + 6) + 50;
	localparam logic signed [DATA_W-1:0] ONE = DATA_W'(1) << FRAC_W;

	logic                     clk = 1'b0;
	logic                     rst;
	logic                     start;
	logic signed [DATA_W-1:0] q0, q1, q2, q3;
	logic                     busy;
	logic                     done;
	logic signed [DATA_W-1:0] c11, c12, c13, c21, c22, c23, c31, c32, c33;
	logic [31:0]              lfsr_state = 32'hf8c0_c4f9;
	int                       cycles = 0;

	dcm_top #(.DATA_W(DATA_W), .FRAC_W(FRAC_W)) i_dut (.*);

	always #50 clk = ~clk;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [DATA_W-1:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[DATA_W-2:0], lfsr_state[0]};
		end
	endtask

	// sign bit, then a magnitude below one half
	task automatic draw_component(output logic signed [DATA_W-1:0] x);
		logic [DATA_W-1:0] sgn;
		logic [DATA_W-1:0] mag;
		take_bits(1, sgn);
		take_bits(FRAC_W - 1, mag);
		x = sgn[0] ? -mag : mag;
	endtask

	task automatic drive_start(input logic signed [DATA_W-1:0] a, b, c, d);
		@(posedge clk);
		#10;
		q0 = a;
		q1 = b;
		q2 = c;
		q3 = d;
		start = 1'b1;
		@(posedge clk);
		#10;
		start = 1'b0;
	endtask

	task automatic wait_done();
		do begin
			@(posedge clk);
			#1;
		end while (!done);
	endtask

	// run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == MAX_CYCLES) begin
			$display("timeout: no finish within %0d cycles, %0d errors", cycles,
				i_dut.i_checker.err_count);
			$display("Verification failed");
			$finish;
		end
	end

	initial begin
		logic signed [DATA_W-1:0] ra, rb, rc, rd;
		rst   = 1'b0;
		start = 1'b0;
		q0    = '0;
		q1    = '0;
		q2    = '0;
		q3    = '0;
		repeat (2) @(posedge clk);
		#10;
		rst = 1'b1;
		repeat (4) @(posedge clk);   // outputs must stay at zero here

		drive_start(ONE, '0, '0, '0);   // identity
		wait_done();

		for (int n = 0; n < N_RAND; n++) begin
			draw_component(ra);
			draw_component(rb);
			draw_component(rc);
			draw_component(rd);
			drive_start(ra, rb, rc, rd);
			wait_done();
		end

		// second start lands while busy and must be dropped
		draw_component(ra);
		draw_component(rb);
		draw_component(rc);
		draw_component(rd);
		drive_start(ra, rb, rc, rd);
		drive_start(rd, rc, rb, ra);
		wait_done();
		repeat ((PROG_LEN + 1) * (DATA_W + 6)) @(posedge clk);   // a whole run, no second done

		$display("run complete after %0d cycles, %0d errors", cycles,
			i_dut.i_checker.err_count);
		if (i_dut.i_checker.err_count == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// File: test/dcm_checker.sv
module dcm_checker #(
	parameter int DATA_W = 32,
	parameter int FRAC_W = 30
) (
	input logic                     clk,
	input logic                     rst,
	input logic                     start,
	input logic                     busy,
	input logic                     done,
	input logic signed [DATA_W-1:0] q0,
	input logic signed [DATA_W-1:0] q1,
	input logic signed [DATA_W-1:0] q2,
	input logic signed [DATA_W-1:0] q3,
	input logic signed [DATA_W-1:0] c11,
	input logic signed [DATA_W-1:0] c12,
	input logic signed [DATA_W-1:0] c13,
	input logic signed [DATA_W-1:0] c21,
	input logic signed [DATA_W-1:0] c22,
	input logic signed [DATA_W-1:0] c23,
	input logic signed [DATA_W-1:0] c31,
	input logic signed [DATA_W-1:0] c32,
	input logic signed [DATA_W-1:0] c33
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam logic signed [DATA_W-1:0] ONE = DATA_W'(1) << FRAC_W;

	int                       err_count = 0;   // read by the testbench
	logic                     seen_start;
	logic                     seen_done;
	logic                     run_open;        // accepted start not yet answered by done
	logic signed [DATA_W-1:0] qc [4];          // quaternion of the accepted start
	logic signed [DATA_W-1:0] act [9];
	logic signed [DATA_W-1:0] exp_c [9];
	logic signed [DATA_W-1:0] p11, p22, p33, p01, p02, p03, p12, p13, p23;
	logic [9*DATA_W-1:0]      all_c;

	// product of two fixed-point values, full width then scaled back
	function automatic logic signed [DATA_W-1:0] fmul(input logic signed [DATA_W-1:0] a,
	                                                  input logic signed [DATA_W-1:0] b);
		logic signed [2*DATA_W-1:0] p;
		p = (2*DATA_W)'(a) * (2*DATA_W)'(b);
		p = p >>> FRAC_W;
		return p[DATA_W-1:0];
	endfunction

	assign act   = '{c11, c12, c13, c21, c22, c23, c31, c32, c33};
	assign all_c = {c11, c12, c13, c21, c22, c23, c31, c32, c33};

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			seen_start <= 1'b0;
			seen_done  <= 1'b0;
			run_open   <= 1'b0;
		end else begin
			if (start && !busy) begin
				seen_start <= 1'b1;
				run_open   <= 1'b1;
			end else if (done) begin
				run_open <= 1'b0;
			end
			if (done) seen_done <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (start && !busy) qc <= '{q0, q1, q2, q3};   // same edge the DUT loads
	end

	//////////////////////////////////////////////////
	// reference matrix
	//////////////////////////////////////////////////

	always_comb begin
		p11 = fmul(qc[1], qc[1]);
		p22 = fmul(qc[2], qc[2]);
		p33 = fmul(qc[3], qc[3]);
		p01 = fmul(qc[0], qc[1]);
		p02 = fmul(qc[0], qc[2]);
		p03 = fmul(qc[0], qc[3]);
		p12 = fmul(qc[1], qc[2]);
		p13 = fmul(qc[1], qc[3]);
		p23 = fmul(qc[2], qc[3]);
		exp_c[0] = ONE - ((p22 + p33) <<< 1);
		exp_c[1] = (p12 + p03) <<< 1;
		exp_c[2] = (p13 - p02) <<< 1;
		exp_c[3] = (p12 - p03) <<< 1;
		exp_c[4] = ONE - ((p11 + p33) <<< 1);
		exp_c[5] = (p23 + p01) <<< 1;
		exp_c[6] = (p13 + p02) <<< 1;
		exp_c[7] = (p23 - p01) <<< 1;
		exp_c[8] = ONE - ((p11 + p22) <<< 1);
	end

	//////////////////////////////////////////////////
	// protocol
	//////////////////////////////////////////////////

	a_idle_after_reset: assert property (@(posedge clk) disable iff (!rst)
		!seen_start |-> !busy && !done)
		else begin
			err_count++;
			$error("busy or done went high before any start was accepted");
		end

	a_zero_after_reset: assert property (@(posedge clk) disable iff (!rst)
		!seen_done && !done |-> all_c == '0)
		else begin
			err_count++;
			$error("[ERROR] c11..c33 expected %h got %h", {9*DATA_W{1'b0}}, $sampled(all_c));
		end

	a_busy_rise: assert property (@(posedge clk) disable iff (!rst)
		start && !busy |=> busy)
		else begin
			err_count++;
			$error("busy did not rise in the cycle after an accepted start");
		end

	a_done_with_busy_fall: assert property (@(posedge clk) disable iff (!rst)
		done == $fell(busy))
		else begin
			err_count++;
			$error("done and the falling edge of busy are not in the same cycle");
		end

	a_done_pulse: assert property (@(posedge clk) disable iff (!rst) done |=> !done)
		else begin
			err_count++;
			$error("done stayed high for more than one cycle");
		end

	// one done for each accepted start, none for an ignored one
	a_done_once: assert property (@(posedge clk) disable iff (!rst) done |-> run_open)
		else begin
			err_count++;
			$error("done came without an accepted start waiting for it");
		end

	a_outputs_hold: assert property (@(posedge clk) disable iff (!rst)
		!done |-> $stable(all_c))
		else begin
			err_count++;
			$error("matrix outputs changed in a cycle without done");
		end

	// one result check per matrix entry
	for (genvar i = 0; i < 9; i++) begin : g_result
		a_entry: assert property (@(posedge clk) disable iff (!rst)
			done |-> act[i] == exp_c[i])
			else begin
				err_count++;
				$error("[ERROR] c%0d%0d expected %h got %h", i / 3 + 1, i % 3 + 1,
					$sampled(exp_c[i]), $sampled(act[i]));
			end
	end

endmodule

bind dcm_top dcm_checker #(.DATA_W(DATA_W), .FRAC_W(FRAC_W)) i_checker (.*);

// File: source/dcm_top.sv
module dcm_top #(
	parameter int DATA_W = 32,
	parameter int FRAC_W = 30
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     start,
	input  logic signed [DATA_W-1:0] q0,
	input  logic signed [DATA_W-1:0] q1,
	input  logic signed [DATA_W-1:0] q2,
	input  logic signed [DATA_W-1:0] q3,
	output logic                     busy,
	output logic                     done,
	output logic signed [DATA_W-1:0] c11,
	output logic signed [DATA_W-1:0] c12,
	output logic signed [DATA_W-1:0] c13,
	output logic signed [DATA_W-1:0] c21,
	output logic signed [DATA_W-1:0] c22,
	output logic signed [DATA_W-1:0] c23,
	output logic signed [DATA_W-1:0] c31,
	output logic signed [DATA_W-1:0] c32,
	output logic signed [DATA_W-1:0] c33
);

	dcm_op_if op_bus ();                    // sequencer to datapath
	mult_if #(.DATA_W(DATA_W)) mul_bus ();  // datapath to multiplier

	dcm_sequencer i_seq (
		.clk     (clk),
		.rst     (rst),
		.start   (start),
		.busy    (busy),
		.done    (done),
		.op_port (op_bus.sequencer)
	);

	dcm_datapath #(.DATA_W(DATA_W), .FRAC_W(FRAC_W)) i_dp (
		.clk (clk), .rst (rst),
		.q0 (q0), .q1 (q1), .q2 (q2), .q3 (q3),
		.c11 (c11), .c12 (c12), .c13 (c13),
		.c21 (c21), .c22 (c22), .c23 (c23),
		.c31 (c31), .c32 (c32), .c33 (c33),
		.op_port (op_bus.datapath),
		.m       (mul_bus.initiator)
	);

	fx_mult #(.DATA_W(DATA_W), .FRAC_W(FRAC_W)) i_mult (
		.clk (clk),
		.rst (rst),
		.m   (mul_bus.target)
	);

endmodule

// File: source/dcm_sequencer.sv
module dcm_sequencer import dcm_pkg::*; (
	input  logic          clk,
	input  logic          rst,
	input  logic          start,
	output logic          busy,
	output logic          done,
	dcm_op_if.sequencer   op_port
);

	localparam int PC_W = $clog2(PROG_LEN + 1);

	localparam micro_op_t LOAD_OP = '{OP_LOAD, Q0, Q0, Q0};

	localparam micro_op_t PROG [PROG_LEN] = '{
		'{OP_MUL, Q1, Q1, P11},   // products
		'{OP_MUL, Q2, Q2, P22},
		'{OP_MUL, Q3, Q3, P33},
		'{OP_MUL, Q0, Q1, P01},
		'{OP_MUL, Q0, Q2, P02},
		'{OP_MUL, Q0, Q3, P03},
		'{OP_MUL, Q1, Q2, P12},
		'{OP_MUL, Q1, Q3, P13},
		'{OP_MUL, Q2, Q3, P23},
		'{OP_ADD, P22, P33, T0},  // c11
		'{OP_DBL, T0, T0, T0},
		'{OP_OMS, T0, T0, C11},
		'{OP_ADD, P11, P33, T1},  // c22
		'{OP_DBL, T1, T1, T1},
		'{OP_OMS, T1, T1, C22},
		'{OP_ADD, P11, P22, T0},  // c33
		'{OP_DBL, T0, T0, T0},
		'{OP_OMS, T0, T0, C33},
		'{OP_ADD, P12, P03, C12},
		'{OP_DBL, C12, C12, C12},
		'{OP_SUB, P13, P02, C13},
		'{OP_DBL, C13, C13, C13},
		'{OP_SUB, P12, P03, C21},
		'{OP_DBL, C21, C21, C21},
		'{OP_ADD, P23, P01, C23},
		'{OP_DBL, C23, C23, C23},
		'{OP_ADD, P13, P02, C31},
		'{OP_DBL, C31, C31, C31},
		'{OP_SUB, P23, P01, C32},
		'{OP_DBL, C32, C32, C32},
		'{OP_PUBLISH, C11, C11, C11}
	};

	seq_state_e       state;
	logic [PC_W-1:0]  pc;        // next table entry
	logic             accept;
	logic             last_op;

	assign accept  = start && (state == S_IDLE || state == S_DONE);
	assign last_op = pc == PC_W'(PROG_LEN);

	assign op_port.issue = accept || state == S_ISSUE;
	assign op_port.op    = (state == S_ISSUE) ? PROG[pc] : LOAD_OP;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= S_IDLE;
			pc    <= '0;
			busy  <= 1'b0;
			done  <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				S_IDLE, S_DONE: begin
					state <= S_IDLE;
					if (accept) begin   // load goes out this cycle
						state <= S_WAIT;
						pc    <= '0;
						busy  <= 1'b1;
					end
				end
				S_ISSUE: begin
					pc    <= pc + 1'b1;
					state <= S_WAIT;
				end
				S_WAIT: begin
					if (op_port.op_done) begin
						if (last_op) begin   // publish finished
							state <= S_DONE;
							busy  <= 1'b0;
							done  <= 1'b1;
						end else begin
							state <= S_ISSUE;
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// File: source/dcm_datapath.sv
module dcm_datapath import dcm_pkg::*; #(
	parameter int DATA_W = 32,
	parameter int FRAC_W = 30
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic signed [DATA_W-1:0] q0,
	input  logic signed [DATA_W-1:0] q1,
	input  logic signed [DATA_W-1:0] q2,
	input  logic signed [DATA_W-1:0] q3,
	output logic signed [DATA_W-1:0] c11,
	output logic signed [DATA_W-1:0] c12,
	output logic signed [DATA_W-1:0] c13,
	output logic signed [DATA_W-1:0] c21,
	output logic signed [DATA_W-1:0] c22,
	output logic signed [DATA_W-1:0] c23,
	output logic signed [DATA_W-1:0] c31,
	output logic signed [DATA_W-1:0] c32,
	output logic signed [DATA_W-1:0] c33,
	dcm_op_if.datapath               op_port,
	mult_if.initiator                m
);

	localparam logic signed [DATA_W-1:0] ONE = DATA_W'(1) << FRAC_W;

	logic signed [DATA_W-1:0] rf [0:C33];   // register file
	micro_op_t                op_q;         // kept for mul writeback and publish
	logic signed [DATA_W-1:0] opa;
	logic signed [DATA_W-1:0] opb;
	logic                     is_mul;

	assign opa    = rf[op_port.op.src_a];
	assign opb    = rf[op_port.op.src_b];
	assign is_mul = op_port.op.opcode == OP_MUL;

	//////////////////////////////////////////////////
	// execute
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (op_port.issue) begin
			op_q <= op_port.op;
			case (op_port.op.opcode)
				OP_LOAD: begin
					rf[Q0] <= q0;
					rf[Q1] <= q1;
					rf[Q2] <= q2;
					rf[Q3] <= q3;
				end
				OP_MUL: begin
					m.a <= opa;   // multiplier samples at start
					m.b <= opb;
				end
				OP_ADD:  rf[op_port.op.dst] <= opa + opb;
				OP_SUB:  rf[op_port.op.dst] <= opa - opb;
				OP_DBL:  rf[op_port.op.dst] <= opa << 1;
				OP_OMS:  rf[op_port.op.dst] <= ONE - opa;
				default: ;   // publish acts at op_done
			endcase
		end else if (m.done) begin
			rf[op_q.dst] <= m.product;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			m.start         <= 1'b0;
			op_port.op_done <= 1'b0;
		end else begin
			m.start         <= op_port.issue && is_mul;
			op_port.op_done <= (op_port.issue && !is_mul) || m.done;
		end
	end

	//////////////////////////////////////////////////
	// output registers
	//////////////////////////////////////////////////

	// loaded while op_done of the publish is high, so they move with done
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			c11 <= '0;
			c12 <= '0;
			c13 <= '0;
			c21 <= '0;
			c22 <= '0;
			c23 <= '0;
			c31 <= '0;
			c32 <= '0;
			c33 <= '0;
		end else if (op_port.op_done && op_q.opcode == OP_PUBLISH) begin
			c11 <= rf[C11];
			c12 <= rf[C12];
			c13 <= rf[C13];
			c21 <= rf[C21];
			c22 <= rf[C22];
			c23 <= rf[C23];
			c31 <= rf[C31];
			c32 <= rf[C32];
			c33 <= rf[C33];
		end
	end

endmodule

// File: source/fx_mult.sv
module fx_mult #(
	parameter int DATA_W = 32,
	parameter int FRAC_W = 30
) (
	input  logic   clk,
	input  logic   rst,
	mult_if.target m
);

	localparam int CNT_W = $clog2(DATA_W);

	typedef enum logic [1:0] {
		M_IDLE,
		M_RUN,
		M_FIN
	} mult_state_e;

	mult_state_e              state;
	logic [CNT_W-1:0]         cnt;        // shift-add step
	logic [2*DATA_W-1:0]      mcand;      // moves left each step
	logic [DATA_W-1:0]        mplier;     // moves right each step
	logic [2*DATA_W-1:0]      acc;
	logic                     neg;        // result sign
	logic [DATA_W-1:0]        mag_a;
	logic [DATA_W-1:0]        mag_b;
	logic signed [2*DATA_W-1:0] prod_full;
	logic signed [2*DATA_W-1:0] prod_shr;

	// most negative value maps onto 2^(DATA_W-1), still fits unsigned
	assign mag_a = m.a[DATA_W-1] ? -m.a : m.a;
	assign mag_b = m.b[DATA_W-1] ? -m.b : m.b;

	assign prod_full = neg ? -$signed(acc) : $signed(acc);
	assign prod_shr  = prod_full >>> FRAC_W;   // drop the extra fraction bits

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state  <= M_IDLE;
			cnt    <= '0;
			m.done <= 1'b0;
		end else begin
			m.done <= 1'b0;
			case (state)
				M_IDLE: begin
					if (m.start) begin
						state <= M_RUN;
						cnt   <= '0;
					end
				end
				M_RUN: begin
					cnt <= cnt + 1'b1;
					if (cnt == CNT_W'(DATA_W - 1)) begin
						state <= M_FIN;
					end
				end
				M_FIN: begin
					state  <= M_IDLE;
					m.done <= 1'b1;
				end
				default: state <= M_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == M_IDLE && m.start) begin
			mcand  <= {{DATA_W{1'b0}}, mag_a};
			mplier <= mag_b;
			acc    <= '0;
			neg    <= m.a[DATA_W-1] ^ m.b[DATA_W-1];
		end else if (state == M_RUN) begin
			if (mplier[0]) begin
				acc <= acc + mcand;
			end
			mcand  <= mcand << 1;
			mplier <= mplier >> 1;
		end
		if (state == M_FIN) begin
			m.product <= prod_shr[DATA_W-1:0];   // low DATA_W bits only
		end
	end

endmodule

// File: source/mult_if.sv
interface mult_if #(
	parameter int DATA_W = 32
);

	logic                     start;    // a and b sampled here
	logic signed [DATA_W-1:0] a;
	logic signed [DATA_W-1:0] b;
	logic signed [DATA_W-1:0] product;  // held until next start
	logic                     done;

	modport initiator (
		output start, a, b,
		input  product, done
	);

	modport target (
		input  start, a, b,
		output product, done
	);

endinterface

// File: source/dcm_op_if.sv
interface dcm_op_if;

	logic                issue;    // one-cycle strobe
	dcm_pkg::micro_op_t  op;       // valid with issue only
	logic                op_done;  // one pulse per issue

	modport sequencer (
		output issue,
		output op,
		input  op_done
	);

	modport datapath (
		input  issue,
		input  op,
		output op_done
	);

endinterface

// File: source/dcm_pkg.sv
package dcm_pkg;

	//////////////////////////////////////////////////
	// micro-op encoding
	//////////////////////////////////////////////////

	typedef enum logic [2:0] {
		OP_LOAD,     // capture q0..q3
		OP_MUL,      // fixed-point product
		OP_ADD,
		OP_SUB,
		OP_DBL,      // x << 1
		OP_OMS,      // ONE - x
		OP_PUBLISH   // work regs to outputs
	} opcode_e;

	typedef enum logic [4:0] {
		Q0, Q1, Q2, Q3,                          // captured quaternion
		P11, P22, P33, P01, P02, P03, P12, P13, P23, // products
		T0, T1,                                  // scratch
		C11, C12, C13,
		C21, C22, C23,
		C31, C32, C33
	} reg_sel_e;

	typedef struct packed {
		opcode_e  opcode;
		reg_sel_e src_a;
		reg_sel_e src_b;   // ignored by single-operand ops
		reg_sel_e dst;
	} micro_op_t;

	//////////////////////////////////////////////////
	// sequencer
	//////////////////////////////////////////////////

	typedef enum logic [1:0] {
		S_IDLE,
		S_ISSUE,
		S_WAIT,
		S_DONE
	} seq_state_e;

	// ops after the load: 9 mul, 9 diagonal, 12 off-diagonal, 1 publish
	localparam int PROG_LEN = 31;

endpackage
